// ==== fetch_stimulus.txt ====
# columns: command, byte address (hex), value (hex; the word for load, the count for expect).
# commands are load, redirect, fence and expect; a column a command does not use holds 0.
load 00000000 00000013
load 00000004 00100093
load 00000008 00200113
load 0000000c 002081b3
load 00000010 00418233
load 00000014 0ff00293
expect 00000000 c
redirect 00000000 0
expect 00000000 8
redirect 00000100 0
expect 00000000 6
load 00000004 cafe0004
load 00000008 cafe0008
fence 00000000 0
redirect 00000000 0
expect 00000000 4
redirect 00000044 0
expect 00000000 2
redirect 00000004 0
expect 00000000 1
redirect 00000048 0
expect 00000000 1
# line 0 alternates between tag 0 and tag 1 above.
# end of stimulus.

// ==== vlog.f ====
fetch_pkg.sv
fetch_pc.sv
icache.sv
line_refill.sv
inst_mem.sv
fetch_top.sv
fetch_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = fetch_tb
FILELIST = vlog.f

SOURCES  = $(shell cat $(FILELIST))
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== fetch_tb.sv ====
`timescale 1ns/100ps

module fetch_tb import fetch_pkg::*; ();

	logic clock = 1'b0;
	logic reset;
	logic redirect;
	logic [addr_len-1:0] redirect_pc;
	logic fence;
	logic inst_ready;
	logic load_we;
	logic [word_addr_len-1:0] load_addr;
	logic [31:0] load_data;
	logic inst_valid;
	logic [addr_len-1:0] inst_pc;
	logic [31:0] inst_data;

	logic [31:0] model_mem [mem_words]; // what the instruction memory should hold.
	logic [63:0] cmd_q [$];
	logic [31:0] addr_q [$];
	logic [31:0] value_q [$];
	int expected_total;
	int limit_cycles;
	bit stimulus_ok;
	bit fetching; // instructions have been fetched, so the cache may hold old words.
	int seed = 40910;
	int errors;
	int checks;
	logic [addr_len-1:0] exp_pc;

	fetch_top uut (
		.clock(clock),
		.reset(reset),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.fence(fence),
		.inst_ready(inst_ready),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.inst_valid(inst_valid),
		.inst_pc(inst_pc),
		.inst_data(inst_data)
	);

	always #50 clock = ~clock;

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// every word gets its own value, built from all eight bits of its word address.
	function automatic logic [31:0] fill_word(input int w);
		logic [7:0] low;
		low = w[7:0];
		return {8'hc3, low, ~low, low ^ 8'h5a};
	endfunction

	task automatic read_stimulus();
		int fd;
		int fields;
		string line;
		logic [63:0] cmd;
		logic [31:0] addr;
		logic [31:0] value;
		stimulus_ok = 1'b0;
		expected_total = 0;
		fd = $fopen("fetch_stimulus.txt", "r");
		if (fd != 0) begin
			stimulus_ok = 1'b1;
			while (!$feof(fd)) begin
				line = "";
				fields = $fgets(line, fd);
				if (line.len() > 1 && line[0] != "#") begin
					fields = $sscanf(line, "%s %h %h", cmd, addr, value);
					if (fields != 3) begin
						$display("stimulus line has too few fields: %s", line);
						stimulus_ok = 1'b0;
					end else if (cmd != 64'("load") && cmd != 64'("redirect")
						&& cmd != 64'("fence") && cmd != 64'("expect")) begin
						$display("stimulus line has an unknown command: %s", line);
						stimulus_ok = 1'b0;
					end else begin
						cmd_q.push_back(cmd);
						addr_q.push_back(addr);
						value_q.push_back(value);
						if (cmd == 64'("expect"))
							expected_total += int'(value);
						else if (cmd == 64'("load") && expected_total > 0)
							expected_total += 1; // the old word is fetched once first.
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_reset();
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		compare_value("inst_valid", 32'(inst_valid), 32'd0);
	endtask

	// the memory is written one word per cycle; the model follows at once.
	task automatic load_word(input logic [addr_len-1:0] byte_addr, input logic [31:0] data);
		@(posedge clock);
		load_we <= 1'b1;
		load_addr <= byte_addr[addr_len-1:2];
		load_data <= data;
		model_mem[byte_addr[mem_index_len+1:2]] = data;
	endtask

	task automatic fill_memory();
		for (int w = 0; w < mem_words; w++)
			load_word(32'(w) << 2, fill_word(w));
	endtask

	task automatic apply_redirect(input logic [addr_len-1:0] target);
		@(posedge clock);
		load_we <= 1'b0;
		redirect <= 1'b1;
		redirect_pc <= target;
		exp_pc = target; // the held or pending instruction is dropped.
		@(posedge clock);
		redirect <= 1'b0;
	endtask

	task automatic apply_fence();
		@(posedge clock);
		load_we <= 1'b0;
		fence <= 1'b1;
		@(posedge clock);
		fence <= 1'b0;
	endtask

	// inst_ready goes low once the last instruction is taken, so the core stalls in place.
	task automatic expect_instructions(input int count);
		int taken;
		logic [31:0] rnd;
		taken = 0;
		while (taken < count) begin
			@(posedge clock);
			load_we <= 1'b0;
			if (inst_valid && inst_ready) begin
				compare_value("inst_pc", inst_pc, exp_pc);
				compare_value("inst_data", inst_data, model_mem[exp_pc[mem_index_len+1:2]]);
				exp_pc = exp_pc + 4;
				taken++;
			end
			rnd = $random(seed);
			if (taken < count)
				inst_ready <= rnd[1:0] != 2'b00;
			else
				inst_ready <= 1'b0;
		end
		fetching = 1'b1;
	endtask

	// the old word is fetched before it is overwritten, so its line is cached with a matching tag.
	task automatic cache_old_word(input logic [addr_len-1:0] byte_addr);
		apply_redirect(byte_addr);
		expect_instructions(1);
	endtask

	task automatic run_commands();
		for (int i = 0; i < cmd_q.size(); i++) begin
			if (cmd_q[i] == 64'("load")) begin
				if (fetching)
					cache_old_word(addr_q[i]);
				load_word(addr_q[i], value_q[i]);
			end else if (cmd_q[i] == 64'("redirect"))
				apply_redirect(addr_q[i]);
			else if (cmd_q[i] == 64'("fence"))
				apply_fence();
			else
				expect_instructions(int'(value_q[i]));
		end
	endtask

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clock);
		$display("timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		fence = 1'b0;
		inst_ready = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		errors = 0;
		checks = 0;
		fetching = 1'b0;
		exp_pc = reset_pc;
		read_stimulus();
		if (!stimulus_ok) begin
			$display("the stimulus file fetch_stimulus.txt could not be read");
			$display("CHECKS FAILED");
			$finish;
		end else begin
			limit_cycles = 40 * expected_total + 1000;
			apply_reset();
			fill_memory(); // the first read waits with rready low, so nothing is fetched yet.
			run_commands();
			$display("%0d checks, %0d errors", checks, errors);
			if (errors == 0)
				$display("ALL CHECKS PASSED");
			else
				$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top import fetch_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     redirect,
	input  logic [addr_len-1:0]      redirect_pc,
	input  logic                     fence,
	input  logic                     inst_ready,
	input  logic                     load_we,
	input  logic [word_addr_len-1:0] load_addr,
	input  logic [31:0]              load_data,
	output logic                     inst_valid,
	output logic [addr_len-1:0]      inst_pc,
	output logic [31:0]              inst_data
);

	logic [addr_len-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [addr_len-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic refill_start;
	logic [addr_len-1:0] refill_addr;
	logic refill_done;
	logic mem_req;
	logic [word_addr_len-1:0] mem_addr;
	logic mem_ack;
	logic [31:0] mem_rdata;

	fetch_pc u_fetch_pc (
		.clock(clock), .reset(reset), .redirect(redirect), .redirect_pc(redirect_pc),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.refill_start(refill_start), .refill_addr(refill_addr), .refill_done(refill_done),
		.inst_valid(inst_valid), .inst_pc(inst_pc), .inst_data(inst_data),
		.inst_ready(inst_ready)
	);

	// write responses are always okay, so bresp is left open.
	icache u_icache (
		.clock(clock), .reset(reset), .fence(fence),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(), .bvalid(bvalid), .bready(bready)
	);

	line_refill u_line_refill (
		.clock(clock), .reset(reset),
		.refill_start(refill_start), .refill_addr(refill_addr), .refill_done(refill_done),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready)
	);

	inst_mem u_inst_mem (
		.clock(clock), .reset(reset),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.load_we(load_we), .load_addr(load_addr), .load_data(load_data)
	);

endmodule

// ==== inst_mem.sv ====
`timescale 1ns/100ps

module inst_mem import fetch_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     mem_req,
	input  logic [word_addr_len-1:0] mem_addr,
	output logic                     mem_ack,
	output logic [31:0]              mem_rdata,
	input  logic                     load_we,
	input  logic [word_addr_len-1:0] load_addr,
	input  logic [31:0]              load_data
);

	logic [31:0] mem [mem_words];
	logic [mem_latency-1:0] req_pipe;
	logic [31:0] data_pipe [mem_latency];

	always_ff @(posedge clock) begin
		if (load_we)
			mem[load_addr[mem_index_len-1:0]] <= load_data; // upper address bits wrap.
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			req_pipe <= '0;
		end else begin
			req_pipe[0] <= mem_req;
			for (int i = 1; i < mem_latency; i++)
				req_pipe[i] <= req_pipe[i-1];
		end
	end

	// the word is read at request time and travels beside its strobe.
	always_ff @(posedge clock) begin
		data_pipe[0] <= mem[mem_addr[mem_index_len-1:0]];
		for (int i = 1; i < mem_latency; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	assign mem_ack = req_pipe[mem_latency-1];
	assign mem_rdata = data_pipe[mem_latency-1];

endmodule

// ==== line_refill.sv ====
`timescale 1ns/100ps

module line_refill import fetch_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     refill_start,
	input  logic [addr_len-1:0]      refill_addr,
	output logic                     refill_done,

	output logic                     mem_req,
	output logic [word_addr_len-1:0] mem_addr,
	input  logic                     mem_ack,
	input  logic [31:0]              mem_rdata,

	output logic [addr_len-1:0]      awaddr,
	output logic                     awvalid,
	input  logic                     awready,
	output logic [31:0]              wdata,
	output logic [3:0]               wstrb,
	output logic                     wvalid,
	input  logic                     wready,
	input  logic                     bvalid,
	output logic                     bready
);

	logic [2:0] state;
	logic [offset_len-3:0] word_cnt;
	cache_addr_t base;
	cache_addr_t cur;
	logic [31:0] word_q;
	logic last;

	always_comb begin
		cur = base;
		cur.f.word = word_cnt;
		cur.f.byte_sel = '0;
	end

	assign last = word_cnt == (offset_len - 2)'(block_words - 1);

	assign mem_req = state == rf_req;
	assign mem_addr = cur.flat[addr_len-1:2];
	assign awaddr = cur.flat;
	assign awvalid = state == rf_aw;
	assign wvalid = state == rf_w;
	assign wdata = word_q;
	assign wstrb = 4'hf;
	assign bready = state == rf_b;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= rf_idle;
			word_cnt <= '0;
			refill_done <= 1'b0;
		end else begin
			refill_done <= 1'b0;
			case (state)
				rf_idle: begin
					if (refill_start) begin
						word_cnt <= '0;
						state <= rf_req;
					end
				end
				rf_req: state <= rf_mem; // request is a single-cycle strobe.
				rf_mem: if (mem_ack) state <= rf_aw;
				rf_aw: if (awready) state <= rf_w;
				rf_w: if (wready) state <= rf_b;
				rf_b: begin
					if (bvalid) begin
						if (last) begin
							refill_done <= 1'b1;
							state <= rf_idle;
						end else begin
							word_cnt <= word_cnt + 1'b1;
							state <= rf_req;
						end
					end
				end
				default: state <= rf_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == rf_idle && refill_start)
			base <= refill_addr;
		if (state == rf_mem && mem_ack)
			word_q <= mem_rdata;
	end

	// the fetch stage waits for refill_done, so it never starts a second line early.
	assert property (@(posedge clock) disable iff (reset)
		refill_start |-> state == rf_idle);

endmodule

// ==== icache.sv ====
`timescale 1ns/100ps

module icache import fetch_pkg::*; (
	input  logic                clock,
	input  logic                reset,
	input  logic                fence,

	input  logic [addr_len-1:0] araddr,
	input  logic                arvalid,
	output logic                arready,

	output logic [31:0]         rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready,

	input  logic [addr_len-1:0] awaddr,
	input  logic                awvalid,
	output logic                awready,

	input  logic [31:0]         wdata,
	input  logic [3:0]          wstrb,
	input  logic                wvalid,
	output logic                wready,

	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready
);

	logic [31:0] data_arr [line_count][block_words];
	logic [tag_len-1:0] tag_arr [line_count];
	logic [line_count-1:0] line_valid;

	cache_addr_t rd_addr;
	cache_addr_t wr_addr; // address captured from the write address channel.
	logic hit;
	logic [1:0] rresp_next;
	logic ar_fire;
	logic r_fire;
	logic aw_fire;
	logic w_fire;
	logic b_fire;

	assign rd_addr = araddr;
	assign hit = line_valid[rd_addr.f.index] && (tag_arr[rd_addr.f.index] == rd_addr.f.tag);

	assign ar_fire = arvalid && arready;
	assign r_fire = rvalid && rready;
	assign aw_fire = awvalid && awready;
	assign w_fire = wvalid && wready;
	assign b_fire = bvalid && bready;

	always_comb begin
		rresp_next = '0;
		rresp_next[resp_miss] = !hit;
	end

	assign bresp = '0;

	// one read in flight: arready drops on accept and comes back once the response is taken.
	always_ff @(posedge clock) begin
		if (reset) begin
			arready <= 1'b1;
			rvalid <= 1'b0;
		end else begin
			arready <= (arready && !arvalid) || (!arready && r_fire);
			rvalid <= (rvalid && !rready) || (!rvalid && ar_fire);
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			rdata <= data_arr[rd_addr.f.index][rd_addr.f.word];
			rresp <= rresp_next;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			awready <= 1'b1;
			wready <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			awready <= (awready && !awvalid) || (!awready && b_fire);
			wready <= (wready && !wvalid) || (!wready && aw_fire);
			bvalid <= (bvalid && !bready) || (!bvalid && w_fire);
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire)
			wr_addr <= awaddr;
	end

	// fence wins over a data beat in the same cycle.
	always_ff @(posedge clock) begin
		if (reset || fence)
			line_valid <= '0;
		else if (w_fire)
			line_valid[wr_addr.f.index] <= 1'b1;
	end

	always_ff @(posedge clock) begin
		if (w_fire) begin
			data_arr[wr_addr.f.index][wr_addr.f.word] <= wdata; // whole word, strobes ignored.
			tag_arr[wr_addr.f.index] <= wr_addr.f.tag;
		end
	end

	// the refill stage sends data only after its address was taken, and always a full word.
	assert property (@(posedge clock) disable iff (reset)
		wvalid |-> wready && wstrb == 4'hf);

endmodule

// ==== fetch_pc.sv ====
`timescale 1ns/100ps

module fetch_pc import fetch_pkg::*; (
	input  logic                clock,
	input  logic                reset,
	input  logic                redirect,
	input  logic [addr_len-1:0] redirect_pc,
	output logic [addr_len-1:0] araddr,
	output logic                arvalid,
	input  logic                arready,
	input  logic [31:0]         rdata,
	input  logic [1:0]          rresp,
	input  logic                rvalid,
	output logic                rready,
	output logic                refill_start,
	output logic [addr_len-1:0] refill_addr,
	input  logic                refill_done,
	output logic                inst_valid,
	output logic [addr_len-1:0] inst_pc,
	output logic [31:0]         inst_data,
	input  logic                inst_ready
);

	logic [2:0] state;
	cache_addr_t pc;
	cache_addr_t line_base;
	logic stale; // the outstanding read belongs to a pc that was redirected away.
	logic ar_fire;
	logic r_fire;
	logic drop;
	logic miss;

	assign arvalid = state == pc_issue;
	assign araddr = pc.flat;
	assign rready = (state == pc_wait) && inst_ready; // back-pressure reaches the cache.
	assign ar_fire = arvalid && arready;
	assign r_fire = rvalid && rready;
	assign drop = stale || redirect;
	assign miss = rresp[resp_miss];
	assign refill_start = r_fire && !drop && miss;
	assign inst_valid = state == pc_present;
	assign inst_pc = pc.flat;

	always_comb begin
		line_base = pc;
		line_base.f.word = '0;
		line_base.f.byte_sel = '0;
	end

	assign refill_addr = line_base.flat;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= pc_idle;
			pc.flat <= reset_pc;
			stale <= 1'b0;
		end else begin
			if (redirect)
				pc.flat <= redirect_pc;
			else if (inst_valid && inst_ready)
				pc.flat <= pc.flat + 4;

			if (r_fire)
				stale <= 1'b0;
			else if (redirect && (ar_fire || state == pc_wait))
				stale <= 1'b1;

			case (state)
				pc_idle: state <= pc_issue;
				pc_issue: if (ar_fire) state <= pc_wait;
				pc_wait: begin
					if (r_fire) begin
						if (drop)
							state <= pc_issue;
						else if (miss)
							state <= pc_refill;
						else
							state <= pc_present;
					end
				end
				pc_refill: if (refill_done) state <= pc_issue; // same pc is fetched again.
				pc_present: if (redirect || inst_ready) state <= pc_issue;
				default: state <= pc_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (r_fire && !drop && !miss)
			inst_data <= rdata;
	end

	// a held instruction stays put until the core takes it or a redirect drops it.
	assert property (@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready && !redirect |=> inst_valid && $stable(inst_pc)
			&& $stable(inst_data));

endmodule

// ==== fetch_pkg.sv ====
package fetch_pkg;

	localparam int addr_len = 32;
	localparam int offset_len = 4;
	localparam int index_len = 2;
	localparam int tag_len = addr_len - offset_len - index_len;
	localparam int block_words = 4;
	localparam int line_count = 4;

	localparam int mem_words = 256;
	localparam int mem_index_len = $clog2(mem_words);
	localparam int word_addr_len = addr_len - 2; // memory is addressed in words.
	localparam int mem_latency = 2;

	localparam logic [addr_len-1:0] reset_pc = '0;
	localparam int resp_miss = 1; // bit 0 of the read response stays zero.

	localparam logic [2:0] pc_idle = 3'd0;
	localparam logic [2:0] pc_issue = 3'd1;
	localparam logic [2:0] pc_wait = 3'd2;
	localparam logic [2:0] pc_refill = 3'd3;
	localparam logic [2:0] pc_present = 3'd4;

	// refill walks request, memory wait, then the three write handshakes per word.
	localparam logic [2:0] rf_idle = 3'd0;
	localparam logic [2:0] rf_req = 3'd1;
	localparam logic [2:0] rf_mem = 3'd2;
	localparam logic [2:0] rf_aw = 3'd3;
	localparam logic [2:0] rf_w = 3'd4;
	localparam logic [2:0] rf_b = 3'd5;

	typedef union packed {
		logic [addr_len-1:0] flat;
		struct packed {
			logic [tag_len-1:0] tag;
			logic [index_len-1:0] index;
			logic [offset_len-3:0] word;
			logic [1:0] byte_sel;
		} f;
	} cache_addr_t;

endpackage
